//--- aes_patterns.hex
// columns: plaintext (128 bits) then expected ciphertext (128 bits)
// key 000102..1e1f, each line is the FIPS-197 appendix C.3 block
00112233445566778899aabbccddeeff8ea2b7ca516745bfeafc49904b496089
00112233445566778899aabbccddeeff8ea2b7ca516745bfeafc49904b496089
00112233445566778899aabbccddeeff8ea2b7ca516745bfeafc49904b496089
00112233445566778899aabbccddeeff8ea2b7ca516745bfeafc49904b496089

//--- filelist.f
aes_pkg.sv
aes_wb_regs.sv
aes_round_ctrl.sv
aes_sub_shift.sv
aes_round_datapath.sv
aes256_enc_top.sv
aes256_enc_sva.sv
tb_aes256_enc.sv

//--- Makefile
# Verilator build and run of the AES-256 encrypter testbench
VERILATOR  ?= verilator
TOP        ?= tb_aes256_enc
RTL_TOP    ?= aes256_enc_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_aes256_enc.sv
/*
 * testbench of the AES-256 block encrypter
 * clock, reset and Wishbone master tasks
 * pattern-driven encryption tests, watchdog and report
 */
`timescale 1ns/1ps

module tb_aes256_enc;

    localparam int NUM_VEC         = 4;
    // encryptions started over the whole run
    localparam int NUM_RUNS        = NUM_VEC + 6;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * 300 + 2000;
    localparam int ACK_LIMIT       = 8;
    localparam int POLL_LIMIT      = 400;

    logic        clk;
    logic        resetn;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;

    // plaintext in the top half, ciphertext below
    logic [255:0] patterns [0:NUM_VEC-1];
    int errors;
    int test_errors;
    int tests_passed;
    int tests_failed;
    int cycle_count = 0;
    int start_cycle;

    aes256_enc_top i_dut (
        .clk(clk), .resetn(resetn),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .dat_r(dat_r), .ack(ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // drive now, return on the falling edge that sees ack
    task automatic bus_access(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        n     = 0;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!ack && n < ACK_LIMIT);
        rdata = dat_r;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        if (!ack)
        begin
            $display("no ack from the DUT for the access to address %0d", addr);
            errors++;
        end
    endtask

    task automatic wb_write(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input logic [3:0] addr, output logic [31:0] data);
        bus_access(1'b0, addr, 32'h0, data);
    endtask

    // pt0 carries the most significant word
    task automatic load_block(input logic [127:0] pt);
        wb_write(aes_pkg::pt0, pt[127:96]);
        wb_write(aes_pkg::pt1, pt[95:64]);
        wb_write(aes_pkg::pt2, pt[63:32]);
        wb_write(aes_pkg::pt3, pt[31:0]);
    endtask

    task automatic read_block(output logic [127:0] ct);
        wb_read(aes_pkg::ct0, ct[127:96]);
        wb_read(aes_pkg::ct1, ct[95:64]);
        wb_read(aes_pkg::ct2, ct[63:32]);
        wb_read(aes_pkg::ct3, ct[31:0]);
    endtask

    task automatic start_block();
        wb_write(aes_pkg::ctrl, 32'h1);
        // count taken on the falling edge after the ack edge
        start_cycle = cycle_count;
    endtask

    task automatic wait_cycle(input int target);
        while (cycle_count < target)
            @(negedge clk);
    endtask

    // status polls with random idle gaps
    task automatic wait_done(input int max_gap);
        logic [31:0] status;
        int polls;
        int gap;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < POLL_LIMIT)
        begin
            gap = $urandom % (max_gap + 1);
            repeat (gap) @(negedge clk);
            wb_read(aes_pkg::status, status);
            polls++;
        end
        if (!status[1])
        begin
            $display("done flag never set after %0d status polls", POLL_LIMIT);
            errors++;
        end
    endtask

    task automatic run_vector(input string name, input int v, input int max_gap);
        logic [127:0] ct;
        load_block(patterns[v][255:128]);
        start_block();
        wait_done(max_gap);
        read_block(ct);
        check(name, patterns[v][127:0], ct);
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors)
        begin
            $display("test %s: ok", name);
            tests_passed++;
        end
        else
        begin
            $display("test %s: %0d errors", name, errors - test_errors);
            tests_failed++;
        end
        test_errors = errors;
    endtask

    initial
    begin
        logic [31:0]  word;
        logic [127:0] block;
        void'($urandom(24));
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        $readmemh("aes_patterns.hex", patterns);
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_w  = '0;
        resetn = 1'b0;
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);

        // registers after reset, 4'hf is unmapped
        wb_read(aes_pkg::status, word);
        check("reset status", 32'h0, word);
        read_block(block);
        check("reset ciphertext", 128'h0, block);
        wb_read(4'hf, word);
        check("unmapped read", 32'h0, word);
        finish_test("reset values");

        run_vector("fips-197 c.3", 0, 0);
        finish_test("fips-197 c.3");

        for (int v = 1; v < NUM_VEC; v++)
            run_vector($sformatf("pattern %0d", v), v, 7);
        finish_test("patterns");

        // ack to finish is 253 cycles, done shows on the read acked one edge later
        load_block(patterns[0][255:128]);
        for (int k = 0; k < 2; k++)
        begin
            start_block();
            wb_read(aes_pkg::status, word);
            check("status after start", 32'h1, word);
            wait_cycle(start_cycle + 253 + k);
            wb_read(aes_pkg::status, word);
            check("status around finish", (k == 0) ? 32'h1 : 32'h2, word);
            wait_done(0);
        end
        read_block(block);
        check("status timing result", patterns[0][127:0], block);
        finish_test("status timing");

        // plaintext writes and a second start during the run
        block = patterns[1][255:128];
        load_block(block);
        start_block();
        load_block(~block);
        wb_write(aes_pkg::ctrl, 32'h1);
        // a restarted run would still be busy here
        wait_cycle(start_cycle + 254);
        wb_read(aes_pkg::status, word);
        check("done after ignored start", 32'h2, word);
        read_block(block);
        check("writes while busy", patterns[1][127:0], block);
        // new run without a reload still sees the first plaintext
        start_block();
        wait_done(3);
        read_block(block);
        check("plaintext kept", patterns[1][127:0], block);
        finish_test("writes while busy");

        // old result readable until the new block is done
        for (int v = 2; v < NUM_VEC; v++)
        begin
            load_block(patterns[v][255:128]);
            start_block();
            read_block(block);
            check("previous result held", patterns[v-1][127:0], block);
            wait_done(3);
            read_block(block);
            check($sformatf("back-to-back %0d", v), patterns[v][127:0], block);
        end
        finish_test("back-to-back");

        $display("%0d tests ok, %0d tests failing, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d clock cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- aes256_enc_sva.sv
/*
 * bound assertions for the encrypter
 * Wishbone ack handshake, round latency
 * no restart of a running block
 */
`timescale 1ns/1ps

module aes256_enc_sva (
    input logic clk,
    input logic resetn,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic start,
    input logic busy,
    input logic finish
);

    // single-cycle ack pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        ack |=> !ack)
        else $error("ack stayed high for more than one cycle");

    // ack answers a request seen on the edge before
    ack_after_request: assert property (@(posedge clk) disable iff (!resetn)
        ack |-> $past(cyc && stb))
        else $error("ack raised without cyc and stb");

    // start is sampled one edge before ack, finish comes 253 cycles after ack
    finish_latency: assert property (@(posedge clk) disable iff (!resetn)
        finish |-> $past(start, 254))
        else $error("finish not 253 cycles after the start ack");

    // a run once started ends on time, so no later start restarts it
    no_restart_when_busy: assert property (@(posedge clk) disable iff (!resetn)
        start |-> ##254 (busy && finish) ##1 !busy)
        else $error("run did not end 253 cycles after its start ack");

endmodule

bind aes_wb_regs aes256_enc_sva i_sva (
    .clk(clk),
    .resetn(resetn),
    .cyc(cyc),
    .stb(stb),
    .ack(ack),
    .start(start),
    .busy(busy),
    .finish(finish)
);

//--- aes256_enc_top.sv
/*
 * top level of the AES-256 block encrypter
 * Wishbone register block, round controller
 * S-box stage and round datapath
 */
`timescale 1ns/1ps

module aes256_enc_top (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [aes_pkg::ADDR_W-1:0] adr,
    input  aes_pkg::word_t             dat_w,
    output aes_pkg::word_t             dat_r,
    output logic                       ack
);

    // control between bus block and sequencer
    logic               start;
    logic               busy;
    logic               finish;
    // sequencer to datapath and S-box stage
    logic               load_key;
    logic               mix_add;
    logic               sub_issue;
    aes_pkg::byte_idx_t byte_idx;
    aes_pkg::round_t    round;
    // data blocks
    aes_pkg::block_t    plaintext;
    aes_pkg::block_t    state_out;
    aes_pkg::block_t    sub_state;

    aes_wb_regs i_regs (
        .clk(clk), .resetn(resetn),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .busy(busy), .finish(finish), .state_out(state_out),
        .dat_r(dat_r), .ack(ack), .start(start), .plaintext(plaintext)
    );

    aes_round_ctrl i_ctrl (
        .clk(clk), .resetn(resetn), .start(start),
        .busy(busy), .finish(finish), .load_key(load_key), .mix_add(mix_add),
        .sub_issue(sub_issue), .byte_idx(byte_idx), .round(round)
    );

    aes_sub_shift i_sub (
        .clk(clk), .resetn(resetn), .sub_issue(sub_issue), .byte_idx(byte_idx),
        .state_out(state_out), .sub_state(sub_state)
    );

    aes_round_datapath i_datapath (
        .clk(clk), .resetn(resetn), .load_key(load_key), .mix_add(mix_add),
        .round(round), .plaintext(plaintext), .sub_state(sub_state),
        .state_out(state_out)
    );

endmodule

//--- aes_round_datapath.sv
/*
 * round datapath of the encrypter
 * state register and AES-256 round-key table
 * MixColumns and AddRoundKey
 */
`timescale 1ns/1ps

module aes_round_datapath (
    input  logic            clk,
    input  logic            resetn,
    input  logic            load_key,
    input  logic            mix_add,
    input  aes_pkg::round_t round,
    input  aes_pkg::block_t plaintext,
    input  aes_pkg::block_t sub_state,
    output aes_pkg::block_t state_out
);

    // expanded schedule of key 000102..1e1f, round 0 first
    localparam logic [0:aes_pkg::NUM_ROUNDS][aes_pkg::BLOCK_W-1:0] ROUND_KEYS = {
        128'h000102030405060708090a0b0c0d0e0f,
        128'h101112131415161718191a1b1c1d1e1f,
        128'ha573c29fa176c498a97fce93a572c09c,
        128'h1651a8cd0244beda1a5da4c10640bade,
        128'hae87dff00ff11b68a68ed5fb03fc1567,
        128'h6de1f1486fa54f9275f8eb5373b8518d,
        128'hc656827fc9a799176f294cec6cd5598b,
        128'h3de23a75524775e727bf9eb45407cf39,
        128'h0bdc905fc27b0948ad5245a4c1871c2f,
        128'h45f5a66017b2d387300d4d33640a820a,
        128'h7ccff71cbeb4fe5413e6bbf0d261a7df,
        128'hf01afafee7a82979d7a5644ab3afe640,
        128'h2541fe719bf500258813bbd55a721c0a,
        128'h4e5a6699a9f24fe07e572baacdf8cdea,
        128'h24fc79ccbf0979e9371ac23c6d68de36
    };

    aes_pkg::block_t round_key;
    aes_pkg::block_t mixed;
    aes_pkg::block_t round_in;

    // multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // one column times the fixed 02 03 01 01 matrix
    function automatic logic [31:0] mix_column(input logic [31:0] col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        mix_column = {
            xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)
        };
    endfunction

    assign round_key = ROUND_KEYS[round];

    // four columns of 32 bits each
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            mixed[aes_pkg::BLOCK_W - 1 - 32*c -: 32] =
                mix_column(sub_state[aes_pkg::BLOCK_W - 1 - 32*c -: 32]);
        end
    end

    // final round has no MixColumns
    assign round_in = (round == aes_pkg::round_t'(aes_pkg::NUM_ROUNDS)) ? sub_state : mixed;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_out <= '0;
        end
        else if (load_key)
        begin
            // initial AddRoundKey
            state_out <= plaintext ^ round_key;
        end
        else if (mix_add)
        begin
            state_out <= round_in ^ round_key;
        end
    end

endmodule

//--- aes_sub_shift.sv
/*
 * byte-serial SubBytes with ShiftRows placement
 * registered FIPS-197 S-box ROM
 * substituted state register
 */
`timescale 1ns/1ps

module aes_sub_shift (
    input  logic               clk,
    input  logic               resetn,
    input  logic               sub_issue,
    input  aes_pkg::byte_idx_t byte_idx,
    input  aes_pkg::block_t    state_out,
    output aes_pkg::block_t    sub_state
);

    // forward S-box, entry 0 in the top byte
    localparam logic [2047:0] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
    };

    logic [7:0]         src_byte;
    logic [7:0]         rom_q;
    logic               issue_q;
    aes_pkg::byte_idx_t idx_q;
    aes_pkg::byte_idx_t dest_idx;

    // byte k of the state, k = 4*column + row
    assign src_byte = state_out[aes_pkg::BLOCK_W - 1 - 8*byte_idx -: 8];

    // ROM read, one new lookup per cycle
    always_ff @(posedge clk)
    begin
        if (sub_issue)
            rom_q <= SBOX[2047 - 8*src_byte -: 8];
    end

    // index follows its byte through the ROM stage
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            issue_q <= 1'b0;
            idx_q   <= '0;
        end
        else
        begin
            issue_q <= sub_issue;
            idx_q   <= byte_idx;
        end
    end

    // row r moves left by r columns
    assign dest_idx = {idx_q[3:2] - idx_q[1:0], idx_q[1:0]};

    always_ff @(posedge clk)
    begin
        if (issue_q)
            sub_state[aes_pkg::BLOCK_W - 1 - 8*dest_idx -: 8] <= rom_q;
    end

endmodule

//--- aes_round_ctrl.sv
/*
 * round sequencer of the encrypter
 * FSM over add_key, sub_bytes, sub_drain, mix_add and done
 * byte counter and round counter
 */
`timescale 1ns/1ps

module aes_round_ctrl (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    output logic               busy,
    output logic               finish,
    output logic               load_key,
    output logic               mix_add,
    output logic               sub_issue,
    output aes_pkg::byte_idx_t byte_idx,
    output aes_pkg::round_t    round
);

    aes_pkg::ctrl_state_e state;
    aes_pkg::ctrl_state_e state_next;
    logic                 last_byte;
    logic                 last_round;

    assign last_byte  = (byte_idx == aes_pkg::byte_idx_t'(aes_pkg::NUM_BYTES - 1));
    assign last_round = (round == aes_pkg::round_t'(aes_pkg::NUM_ROUNDS));

    always_comb
    begin
        state_next = state;
        case (state)
            aes_pkg::idle:      if (start) state_next = aes_pkg::add_key;
            aes_pkg::add_key:   state_next = aes_pkg::sub_bytes;
            // 16 lookups, one byte per cycle
            aes_pkg::sub_bytes: if (last_byte) state_next = aes_pkg::sub_drain;
            // last ROM output lands here
            aes_pkg::sub_drain: state_next = aes_pkg::mix_add;
            aes_pkg::mix_add:
                state_next = last_round ? aes_pkg::done : aes_pkg::sub_bytes;
            aes_pkg::done:      state_next = aes_pkg::idle;
            default:            state_next = aes_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state    <= aes_pkg::idle;
            byte_idx <= '0;
            round    <= '0;
        end
        else
        begin
            state <= state_next;
            if (state == aes_pkg::sub_bytes)
                byte_idx <= byte_idx + 1'b1;
            else
                byte_idx <= '0;
            // round 0 is the initial key add, rounds 1..14 follow
            if (state == aes_pkg::add_key)
                round <= aes_pkg::round_t'(1);
            else if (state == aes_pkg::mix_add && !last_round)
                round <= round + 1'b1;
            else if (state == aes_pkg::done)
                round <= '0;
        end
    end

    assign busy      = (state != aes_pkg::idle);
    assign finish    = (state == aes_pkg::done);
    assign load_key  = (state == aes_pkg::add_key);
    assign mix_add   = (state == aes_pkg::mix_add);
    assign sub_issue = (state == aes_pkg::sub_bytes);

endmodule

//--- aes_wb_regs.sv
/*
 * Wishbone classic slave of the encrypter
 * control, status, plaintext and ciphertext registers
 * start pulse and done flag
 */
`timescale 1ns/1ps

module aes_wb_regs (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [aes_pkg::ADDR_W-1:0] adr,
    input  aes_pkg::word_t             dat_w,
    input  logic                       busy,
    input  logic                       finish,
    input  aes_pkg::block_t            state_out,
    output aes_pkg::word_t             dat_r,
    output logic                       ack,
    output logic                       start,
    output aes_pkg::block_t            plaintext
);

    logic            access;
    logic            wr_en;
    logic            done_q;
    aes_pkg::block_t ciphertext;
    aes_pkg::word_t  rd_word;

    // new access, ack not yet given
    assign access = cyc && stb && !ack;
    assign wr_en  = access && we;
    // controller leaves idle on the same edge that raises ack
    assign start  = wr_en && (adr == aes_pkg::ctrl) && dat_w[0] && !busy;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ack        <= 1'b0;
            done_q     <= 1'b0;
            plaintext  <= '0;
            ciphertext <= '0;
        end
        else
        begin
            ack <= access;
            if (start)
                done_q <= 1'b0;
            else if (finish)
                done_q <= 1'b1;
            // result held until the next block finishes
            if (finish)
                ciphertext <= state_out;
            // pt0 is the most significant word
            if (wr_en && !busy)
            begin
                case (adr)
                    aes_pkg::pt0: plaintext[127:96] <= dat_w;
                    aes_pkg::pt1: plaintext[95:64]  <= dat_w;
                    aes_pkg::pt2: plaintext[63:32]  <= dat_w;
                    aes_pkg::pt3: plaintext[31:0]   <= dat_w;
                    default:      plaintext         <= plaintext;
                endcase
            end
        end
    end

    // read mux, unmapped words give zero
    always_comb
    begin
        case (adr)
            aes_pkg::status: rd_word = aes_pkg::word_t'({done_q, busy});
            aes_pkg::ct0:    rd_word = ciphertext[127:96];
            aes_pkg::ct1:    rd_word = ciphertext[95:64];
            aes_pkg::ct2:    rd_word = ciphertext[63:32];
            aes_pkg::ct3:    rd_word = ciphertext[31:0];
            default:         rd_word = '0;
        endcase
    end

    // read data lands with ack
    always_ff @(posedge clk)
    begin
        if (access && !we)
            dat_r <= rd_word;
    end

endmodule

//--- aes_pkg.sv
/*
 * shared definitions for the AES-256 block encrypter
 * bus, address and block widths, round count
 * block, word, round and byte index types
 * controller state and register map enums
 */
package aes_pkg;

    localparam int WORD_W    = 32;
    localparam int BLOCK_W   = 128;
    localparam int ADDR_W    = 4;
    // bytes in one AES state
    localparam int NUM_BYTES = 16;
    // AES-256, fixed by the round-key table
    localparam int NUM_ROUNDS = 14;

    // byte 0 sits in the top bits, column-major as in FIPS-197
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [3:0]         round_t;
    typedef logic [3:0]         byte_idx_t;

    typedef enum logic [2:0] {
        idle      = 3'd0,
        add_key   = 3'd1,
        sub_bytes = 3'd2,
        sub_drain = 3'd3,
        mix_add   = 3'd4,
        done      = 3'd5
    } ctrl_state_e;

    // word addresses of the bus registers
    typedef enum logic [ADDR_W-1:0] {
        ctrl = 4'd0, status = 4'd1,
        pt0 = 4'd2, pt1 = 4'd3, pt2 = 4'd4, pt3 = 4'd5,
        ct0 = 4'd6, ct1 = 4'd7, ct2 = 4'd8, ct3 = 4'd9
    } reg_addr_e;

endpackage
